// ==== hdl/stk_pkg.sv ====
// shared types and APB address map for the stack transfer subsystem, imported by every block
`default_nettype none

package stk_pkg;

    // register codes double as APB word addresses
    typedef enum logic [3:0] {
        REG_A  = 4'd0,
        REG_B  = 4'd1,
        REG_DP = 4'd2,
        REG_CC = 4'd3,
        REG_X  = 4'd4,
        REG_Y  = 4'd5,
        REG_U  = 4'd6,
        REG_S  = 4'd7,
        REG_PC = 4'd8
    } reg_id_e;

    typedef enum logic {
        OP_PUSH = 1'b0,
        OP_PULL = 1'b1
    } stk_op_e;

    // host write into the register file
    typedef struct packed {
        logic        en;
        reg_id_e     id;
        logic [15:0] data;   // 8-bit registers take the low byte
    } reg_wr_t;

    typedef struct packed {
        logic        valid;
        stk_op_e     op;
        logic        use_u;  // 1 selects U as the active pointer
        logic [7:0]  mask;   // 6809 postbyte
    } stk_cmd_t;

    typedef struct packed {
        logic        we;
        logic [15:0] addr;   // only the low STACK_AW bits reach the RAM
        logic [7:0]  wdata;
    } ram_req_t;

    localparam logic [15:0] ADDR_CMD      = 16'd9;   // mask 7:0, op 8, use_u 9
    localparam logic [15:0] ADDR_STATUS   = 16'd10;  // bit 0 is busy
    localparam logic [15:0] ADDR_MEM_BASE = 16'd256; // read-only window onto the stack RAM

endpackage

`default_nettype wire

// ==== hdl/stk_ram.sv ====
// byte-wide stack memory, sequencer port plus a read-only host window
`default_nettype none

module stk_ram #(
    parameter int STACK_AW = 8
) (
    input  logic                clk,
    input  stk_pkg::ram_req_t   req,
    input  logic [STACK_AW-1:0] mem_addr,
    output logic [7:0]          rdata,
    output logic [7:0]          mem_rdata
);

    logic [7:0] mem [2**STACK_AW];

    always_ff @(posedge clk) begin
        if (req.we)
            mem[req.addr[STACK_AW-1:0]] <= req.wdata;
    end

    assign rdata     = mem[req.addr[STACK_AW-1:0]];  // pull data, same cycle
    assign mem_rdata = mem[mem_addr];

endmodule

`default_nettype wire

// ==== hdl/stk_regs.sv ====
// 6809-style register file, serves push bytes and takes pull bytes for the stack sequencer
`default_nettype none

module stk_regs (
    input  logic                clk,
    input  logic                rst,
    input  stk_pkg::reg_wr_t    host_wr,
    input  stk_pkg::reg_id_e    rd_id,
    input  logic [7:0]          psh_sel,
    input  logic                push_en,
    input  logic                pul_en,
    input  logic                psh_hilon,
    input  logic                psh_ussel,
    input  logic [7:0]          pul_data,
    output logic [15:0]         rd_data,
    output logic [7:0]          psh_byte,
    output logic [7:0]          psh_bit,
    output logic [15:0]         psh_addr
);
    import stk_pkg::*;

    logic [7:0]  a, b, dp, cc;
    logic [15:0] x, y, u, s, pc;
    logic [15:0] psh_other;

    // replace one byte of a 16-bit register
    function automatic logic [15:0] put_byte(logic [15:0] r, logic hi, logic [7:0] d);
        logic [15:0] v;
        v = r;
        if (hi)
            v[15:8] = d;
        else
            v[7:0] = d;
        return v;
    endfunction

    assign psh_addr  = psh_ussel ? u : s;
    assign psh_other = psh_ussel ? s : u;  // bit 6 names the idle pointer

    // pushes walk from PC down, pulls from CC up
    always_comb begin
        psh_bit = 8'h00;
        if (pul_en) begin
            for (int i = 7; i >= 0; i--)
                if (psh_sel[i])
                    psh_bit = 8'h01 << i;
        end else begin
            for (int i = 0; i < 8; i++)
                if (psh_sel[i])
                    psh_bit = 8'h01 << i;
        end
    end

    always_comb begin
        case (psh_bit)
            8'h01:   psh_byte = cc;
            8'h02:   psh_byte = a;
            8'h04:   psh_byte = b;
            8'h08:   psh_byte = dp;
            8'h10:   psh_byte = psh_hilon ? x[15:8] : x[7:0];
            8'h20:   psh_byte = psh_hilon ? y[15:8] : y[7:0];
            8'h40:   psh_byte = psh_hilon ? psh_other[15:8] : psh_other[7:0];
            8'h80:   psh_byte = psh_hilon ? pc[15:8] : pc[7:0];
            default: psh_byte = 8'h00;
        endcase
    end

    always_comb begin
        case (rd_id)
            REG_A:   rd_data = {8'h00, a};
            REG_B:   rd_data = {8'h00, b};
            REG_DP:  rd_data = {8'h00, dp};
            REG_CC:  rd_data = {8'h00, cc};
            REG_X:   rd_data = x;
            REG_Y:   rd_data = y;
            REG_U:   rd_data = u;
            REG_S:   rd_data = s;
            REG_PC:  rd_data = pc;
            default: rd_data = 16'h0000;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            a  <= 8'h00;
            b  <= 8'h00;
            dp <= 8'h00;
            cc <= 8'h00;
            x  <= 16'h0000;
            y  <= 16'h0000;
            u  <= 16'h0000;
            s  <= 16'h0000;
            pc <= 16'h0000;
        end else if (host_wr.en) begin  // only reaches here while idle
            case (host_wr.id)
                REG_A:   a  <= host_wr.data[7:0];
                REG_B:   b  <= host_wr.data[7:0];
                REG_DP:  dp <= host_wr.data[7:0];
                REG_CC:  cc <= host_wr.data[7:0];
                REG_X:   x  <= host_wr.data;
                REG_Y:   y  <= host_wr.data;
                REG_U:   u  <= host_wr.data;
                REG_S:   s  <= host_wr.data;
                REG_PC:  pc <= host_wr.data;
                default: ;
            endcase
        end else begin
            if (push_en) begin  // pre-decrement
                if (psh_ussel)
                    u <= u - 16'd1;
                else
                    s <= s - 16'd1;
            end
            if (pul_en) begin
                case (psh_bit)
                    8'h01: cc <= pul_data;
                    8'h02: a  <= pul_data;
                    8'h04: b  <= pul_data;
                    8'h08: dp <= pul_data;
                    8'h10: x  <= put_byte(x, psh_hilon, pul_data);
                    8'h20: y  <= put_byte(y, psh_hilon, pul_data);
                    8'h40: begin
                        if (psh_ussel)
                            s <= put_byte(s, psh_hilon, pul_data);
                        else
                            u <= put_byte(u, psh_hilon, pul_data);
                    end
                    8'h80: pc <= put_byte(pc, psh_hilon, pul_data);
                    default: ;
                endcase
                if (psh_ussel)  // post-increment, never the register just loaded
                    u <= u + 16'd1;
                else
                    s <= s + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/stk_seq.sv ====
// push/pull sequencer, walks the postbyte mask and moves one stack byte per cycle
`default_nettype none

module stk_seq #(
    parameter int STACK_AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  stk_pkg::stk_cmd_t   cmd,
    input  logic [7:0]          psh_bit,
    input  logic [7:0]          psh_byte,
    input  logic [15:0]         psh_addr,
    output logic                busy,
    output logic [7:0]          psh_sel,
    output logic                push_en,
    output logic                pul_en,
    output logic                psh_hilon,
    output logic                psh_ussel,
    output stk_pkg::ram_req_t   ram_req
);
    import stk_pkg::*;

    localparam logic [15:0] AW_MASK = 16'((1 << STACK_AW) - 1);

    logic [7:0]  mask_q;
    stk_op_e     op_q;
    logic        use_u_q;
    logic        hilon_q;
    logic        wide;         // served register is 16 bits
    logic        first_hilon;  // low byte first on push, high byte first on pull
    logic        last_byte;
    logic [15:0] addr_calc;

    assign busy      = |mask_q;
    assign psh_sel   = mask_q;
    assign push_en   = busy && (op_q == OP_PUSH);
    assign pul_en    = busy && (op_q == OP_PULL);
    assign psh_hilon = hilon_q;
    assign psh_ussel = use_u_q;

    assign wide        = |psh_bit[7:4];
    assign first_hilon = (op_q == OP_PULL);
    assign last_byte   = !wide || (hilon_q != first_hilon);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            mask_q  <= 8'h00;
            op_q    <= OP_PUSH;
            use_u_q <= 1'b0;
            hilon_q <= 1'b0;
        end else if (cmd.valid) begin
            mask_q  <= cmd.mask;
            op_q    <= cmd.op;
            use_u_q <= cmd.use_u;
            hilon_q <= (cmd.op == OP_PULL);
        end else if (busy) begin
            if (last_byte) begin
                mask_q  <= mask_q & ~psh_bit;  // register done
                hilon_q <= first_hilon;
            end else begin
                hilon_q <= !hilon_q;
            end
        end
    end

    // push writes below the pointer, pull reads at it
    assign addr_calc = push_en ? psh_addr - 16'd1 : psh_addr;

    always_comb begin
        ram_req.we    = push_en;
        ram_req.addr  = addr_calc & AW_MASK;  // wraps inside the RAM
        ram_req.wdata = psh_byte;
    end

endmodule

`default_nettype wire

// ==== hdl/stk_apb.sv ====
// APB slave for register, command, status and stack memory window accesses
`default_nettype none

module stk_apb #(
    parameter int STACK_AW = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [15:0]         paddr,
    input  logic [15:0]         pwdata,
    output logic [15:0]         prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                busy,
    input  logic [15:0]         rd_data,
    input  logic [7:0]          mem_rdata,
    output stk_pkg::reg_wr_t    host_wr,
    output stk_pkg::reg_id_e    rd_id,
    output stk_pkg::stk_cmd_t   cmd,
    output logic [STACK_AW-1:0] mem_addr
);
    import stk_pkg::*;

    logic        setup, access;
    logic        is_reg, is_cmd, is_stat, is_mem;
    logic        err_nx;
    logic [15:0] mem_off;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    assign mem_off = paddr - ADDR_MEM_BASE;
    assign is_reg  = paddr < ADDR_CMD;
    assign is_cmd  = paddr == ADDR_CMD;
    assign is_stat = paddr == ADDR_STATUS;
    assign is_mem  = (paddr >= ADDR_MEM_BASE) && ((mem_off >> STACK_AW) == 16'd0);

    assign rd_id    = reg_id_e'(paddr[3:0]);
    assign mem_addr = mem_off[STACK_AW-1:0];
    assign pready   = 1'b1;

    // busy cannot rise between setup and access, so setup-phase busy is safe
    assign err_nx = !(is_reg || is_cmd || is_stat || is_mem)
                  || (pwrite && is_mem)
                  || (pwrite && busy && (is_reg || is_cmd));

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            pslverr <= 1'b0;
        else
            pslverr <= setup && err_nx;  // lands in the access phase
    end

    // refused writes never reach the core
    always_comb begin
        host_wr.en   = access && pwrite && is_reg && !pslverr;
        host_wr.id   = rd_id;
        host_wr.data = pwdata;
        cmd.valid    = access && pwrite && is_cmd && !pslverr;
        cmd.op       = stk_op_e'(pwdata[8]);
        cmd.use_u    = pwdata[9];
        cmd.mask     = pwdata[7:0];
    end

    always_comb begin
        if (is_reg)
            prdata = rd_data;
        else if (is_stat)
            prdata = {15'h0000, busy};
        else if (is_mem)
            prdata = {8'h00, mem_rdata};
        else
            prdata = 16'h0000;
    end

endmodule

`default_nettype wire

// ==== hdl/stk_top.sv ====
// stack transfer subsystem top, APB slave wrapped around registers, sequencer and stack RAM
`default_nettype none

module stk_top #(
    parameter int STACK_AW = 8
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [15:0] paddr,
    input  logic [15:0] pwdata,
    output logic [15:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import stk_pkg::*;

    reg_wr_t             host_wr;
    reg_id_e             rd_id;
    stk_cmd_t            cmd;
    ram_req_t            ram_req;
    logic                busy;
    logic [15:0]         rd_data;
    logic [7:0]          psh_sel, psh_byte, psh_bit;
    logic [15:0]         psh_addr;
    logic                push_en, pul_en, psh_hilon, psh_ussel;
    logic [7:0]          rdata, mem_rdata;
    logic [STACK_AW-1:0] mem_addr;

    stk_apb #(.STACK_AW(STACK_AW)) u_apb (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .busy, .rd_data, .mem_rdata,
        .host_wr, .rd_id, .cmd, .mem_addr
    );

    stk_regs u_regs (
        .clk, .rst, .host_wr, .rd_id, .psh_sel, .push_en, .pul_en,
        .psh_hilon, .psh_ussel, .pul_data(rdata),
        .rd_data, .psh_byte, .psh_bit, .psh_addr
    );

    stk_seq #(.STACK_AW(STACK_AW)) u_seq (
        .clk, .rst, .cmd, .psh_bit, .psh_byte, .psh_addr,
        .busy, .psh_sel, .push_en, .pul_en, .psh_hilon, .psh_ussel, .ram_req
    );

    stk_ram #(.STACK_AW(STACK_AW)) u_ram (
        .clk, .req(ram_req), .mem_addr, .rdata, .mem_rdata
    );

endmodule

`default_nettype wire

// ==== verif/stk_assert.sv ====
// concurrent checks on sequencer strobes and APB error timing that are bound into the subsystem top
`default_nettype none

module stk_assert (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic push_en,
    input logic pul_en,
    input logic penable,
    input logic pslverr
);

    // sequencer leaves reset idle
    a_idle_after_rst: assert property (@(posedge clk) $past(rst) |-> !busy)
        else $error("busy set in the cycle after reset");

    // a command taken while busy would flip direction in the next cycle
    a_one_direction: assert property (@(posedge clk) disable iff (rst)
        !(push_en && (pul_en || $past(pul_en))) && !(pul_en && $past(push_en)))
        else $error("push_en and pul_en high together or back to back");

    a_err_in_access: assert property (@(posedge clk) disable iff (rst) pslverr |-> penable)
        else $error("pslverr high outside an access phase");  // response only with penable

endmodule

`default_nettype wire

// ==== verif/stk_tb.sv ====
// top-level testbench that drives the stack subsystem over APB and checks it against a model
`default_nettype none

module stk_tb;
    import stk_pkg::*;

    localparam int N_ROUNDS   = 4;
    localparam int POLL_LIMIT = 50;   // status polls before giving up

    logic        clk, rst;
    logic        psel, penable, pwrite;
    logic [15:0] paddr, pwdata, prdata;
    logic        pready, pslverr;

    logic [15:0] lfsr;
    logic [15:0] model_reg [9];   // indexed by reg_id_e code
    logic [7:0]  model_mem [256];
    int          err_cnt;

    stk_top #(.STACK_AW(8)) dut (
        .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr
    );

    bind stk_top stk_assert u_assert (
        .clk(clk), .rst(rst), .busy(busy), .push_en(push_en), .pul_en(pul_en),
        .penable(penable), .pslverr(pslverr)
    );

    always #10 clk = ~clk;

    // fibonacci lfsr x^16+x^14+x^13+x^11+1 stepped once per bit taken
    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        logic        fb;
        v = 16'h0000;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[14:0], fb};
        end
        return v;
    endfunction

    // 6809 postbyte bit to register with bit 6 as the idle pointer
    function automatic logic [3:0] reg_of_bit(int b, logic [3:0] oth);
        case (b)
            0:       return REG_CC;
            1:       return REG_A;
            2:       return REG_B;
            3:       return REG_DP;
            4:       return REG_X;
            5:       return REG_Y;
            6:       return oth;
            default: return REG_PC;
        endcase
    endfunction

    function automatic int byte_count(logic [7:0] mask);
        int n;
        n = 0;
        for (int b = 0; b < 8; b++)
            if (mask[b])
                n += (b >= 4) ? 2 : 1;  // upper four bits are 16-bit registers
        return n;
    endfunction

    task automatic fail_stop(string why);
        err_cnt++;
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(string name, logic [15:0] exp, logic [15:0] act);
        assert (act === exp) else
            fail_stop($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    // one APB transfer with an idle cycle after it
    task automatic apb_xfer(logic wr, logic [15:0] addr, logic [15:0] data,
                            output logic [15:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        rdata   = prdata;   // settled since the last rising edge
        err     = pslverr;
        penable = 1'b1;
        check_eq("pready", 16'h0001, 16'(pready));
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_expect(logic [15:0] addr, logic [15:0] data, logic exp_err,
                                string name);
        logic [15:0] rd;
        logic        e;
        apb_xfer(1'b1, addr, data, rd, e);
        check_eq($sformatf("%s_pslverr", name), 16'(exp_err), 16'(e));
    endtask

    task automatic read_expect(logic [15:0] addr, logic [15:0] exp, string name);
        logic [15:0] rd;
        logic        e;
        apb_xfer(1'b0, addr, 16'h0000, rd, e);
        check_eq($sformatf("%s_pslverr", name), 16'h0000, 16'(e));
        check_eq(name, exp, rd);
    endtask

    task automatic load_random_regs(int skip, string name);
        logic [15:0] v;
        for (int i = 0; i < 9; i++) begin
            if (i != skip) begin
                v = rand_bits(16);
                write_expect(16'(i), v, 1'b0, $sformatf("%s_wr%0d", name, i));
                model_reg[i] = (i < 4) ? {8'h00, v[7:0]} : v;  // A, B, DP, CC keep one byte
            end
        end
    endtask

    task automatic check_regs(string name);
        for (int i = 0; i < 9; i++)
            read_expect(16'(i), model_reg[i], $sformatf("%s_reg%0d", name, i));
    endtask

    task automatic wait_idle();
        logic [15:0] st;
        logic        e;
        int          n;
        st = 16'h0001;
        n  = 0;
        while (st[0] && n < POLL_LIMIT) begin
            apb_xfer(1'b0, ADDR_STATUS, 16'h0000, st, e);
            n++;
        end
        if (st[0])
            fail_stop("timeout: busy still set after the poll limit");
    endtask

    // pre-decrement with the low byte first from PC down to CC
    task automatic model_push(logic use_u, logic [7:0] mask, output logic [7:0] oth_addr);
        logic [3:0]  act, oth;
        logic [15:0] ptr, v;
        act = use_u ? REG_U : REG_S;
        oth = use_u ? REG_S : REG_U;
        ptr = model_reg[act];
        for (int b = 7; b >= 0; b--) begin
            if (mask[b]) begin
                v   = model_reg[reg_of_bit(b, oth)];
                ptr = ptr - 16'd1;
                model_mem[ptr[7:0]] = v[7:0];
                if (b >= 4) begin
                    ptr = ptr - 16'd1;
                    model_mem[ptr[7:0]] = v[15:8];
                end
                if (b == 6)
                    oth_addr = ptr[7:0];
            end
        end
        model_reg[act] = ptr;
    endtask

    // high byte first with post-increment from CC up to PC
    task automatic model_pull(logic use_u, logic [7:0] mask);
        logic [3:0]  act, oth, id;
        logic [15:0] ptr;
        act = use_u ? REG_U : REG_S;
        oth = use_u ? REG_S : REG_U;
        ptr = model_reg[act];
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                id = reg_of_bit(b, oth);
                if (b >= 4) begin
                    model_reg[id] = {model_mem[ptr[7:0]], model_mem[ptr[7:0] + 8'd1]};
                    ptr = ptr + 16'd2;
                end else begin
                    model_reg[id] = {8'h00, model_mem[ptr[7:0]]};
                    ptr = ptr + 16'd1;
                end
            end
        end
        model_reg[act] = ptr;
    endtask

    task automatic push_pull_round(logic use_u, string tag);
        logic [7:0]  mask, oth_addr, a;
        logic [3:0]  act, oth;
        logic [15:0] old_ptr, base;
        logic [15:0] saved [9];
        int          nbytes;
        act = use_u ? REG_U : REG_S;
        oth = use_u ? REG_S : REG_U;
        load_random_regs(-1, tag);
        mask    = 8'(rand_bits(8));
        saved   = model_reg;
        old_ptr = model_reg[act];
        nbytes  = byte_count(mask);

        write_expect(ADDR_CMD, {6'h00, use_u, 1'b0, mask}, 1'b0, $sformatf("%s_push", tag));
        model_push(use_u, mask, oth_addr);
        wait_idle();
        read_expect({12'h000, act}, old_ptr - 16'(nbytes), $sformatf("%s_push_ptr", tag));
        check_regs($sformatf("%s_push", tag));
        base = model_reg[act];
        for (int k = 0; k < nbytes; k++) begin
            a = base[7:0] + 8'(k);
            read_expect(ADDR_MEM_BASE + {8'h00, a}, {8'h00, model_mem[a]},
                        $sformatf("%s_mem%0d", tag, k));
        end
        if (mask[6]) begin  // idle pointer stored high byte at the lower address
            read_expect(ADDR_MEM_BASE + {8'h00, oth_addr}, {8'h00, saved[oth][15:8]},
                        $sformatf("%s_oth_hi", tag));
            read_expect(ADDR_MEM_BASE + {8'h00, oth_addr + 8'd1}, {8'h00, saved[oth][7:0]},
                        $sformatf("%s_oth_lo", tag));
        end

        load_random_regs(int'(act), $sformatf("%s_ovr", tag));
        write_expect(ADDR_CMD, {6'h00, use_u, 1'b1, mask}, 1'b0, $sformatf("%s_pull", tag));
        model_pull(use_u, mask);
        wait_idle();
        read_expect({12'h000, act}, old_ptr, $sformatf("%s_pull_ptr", tag));
        for (int b = 0; b < 8; b++)
            if (mask[b])
                read_expect({12'h000, reg_of_bit(b, oth)}, saved[reg_of_bit(b, oth)],
                            $sformatf("%s_restore%0d", tag, b));
        check_regs($sformatf("%s_pull", tag));
    endtask

    task automatic busy_error_test();
        logic [7:0]  oth_addr;
        logic [15:0] rd;
        logic        e;
        // full mask keeps busy up for twelve cycles
        write_expect(ADDR_CMD, {6'h00, 1'b0, 1'b0, 8'hff}, 1'b0, "busy_push");
        write_expect({12'h000, REG_A}, rand_bits(16), 1'b1, "busy_reg_wr");
        write_expect(ADDR_CMD, {6'h00, 1'b0, 1'b1, 8'hff}, 1'b1, "busy_cmd_wr");
        model_push(1'b0, 8'hff, oth_addr);
        wait_idle();
        check_regs("busy");
        write_expect(16'd11, 16'h1234, 1'b1, "unmapped_wr");
        apb_xfer(1'b0, 16'd512, 16'h0000, rd, e);
        check_eq("unmapped_rd_pslverr", 16'h0001, 16'(e));
        write_expect(ADDR_MEM_BASE + 16'd5, 16'h00a5, 1'b1, "mem_window_wr");
        check_regs("after_errors");
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 16'h0000;
        pwdata  = 16'h0000;
        lfsr    = 16'd64763;
        err_cnt = 0;
        for (int i = 0; i < 9; i++)
            model_reg[i] = 16'h0000;
        repeat (10) @(negedge clk);
        rst = 1'b0;

        check_regs("reset");
        read_expect(ADDR_STATUS, 16'h0000, "reset_status");
        load_random_regs(-1, "rw");
        check_regs("rw");
        repeat (N_ROUNDS) push_pull_round(1'b0, "s");
        repeat (N_ROUNDS) push_pull_round(1'b1, "u");
        busy_error_test();

        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/stk_pkg.sv
hdl/stk_ram.sv
hdl/stk_regs.sv
hdl/stk_seq.sv
hdl/stk_apb.sv
hdl/stk_top.sv
verif/stk_assert.sv
verif/stk_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module stk_tb -f list.f -o stk_sim
rc=0
./obj_dir/stk_sim > sim.log 2>&1 || rc=$?
cat sim.log
if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
if [ "$rc" -ne 0 ] || ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without completing"
    exit 1
fi
